// ==== design/decim_pkg.sv ====
// Decimator shared types
// Sample, sum and APB vectors, beat structs and register map
`default_nettype none

package decim_pkg;

    // Widths with a meaning
    typedef logic [7:0]  sample_t;
    typedef logic [15:0] sum_t;
    typedef logic [7:0]  blk_len_t;
    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // Drain output beat
    typedef struct packed {
        logic    valid;
        sample_t data;
    } drain_beat_t;

    // Finished block sum from the accumulator
    typedef struct packed {
        logic valid;
        sum_t sum;
    } acc_result_t;

    // APB request from the host
    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    // APB response back to the host
    typedef struct packed {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    // Register offsets
    localparam apb_addr_t REG_CTRL   = 8'h00;
    localparam apb_addr_t REG_STATUS = 8'h04;
    localparam apb_addr_t REG_RESULT = 8'h08;

    // Samples per block out of reset
    localparam blk_len_t BLK_LEN_RESET = 8'd4;

endpackage

`default_nettype wire

// ==== design/async_fifo.sv ====
// Dual-clock sample FIFO
// Gray-coded pointers with two-flop synchronizers in each direction
`timescale 1ns/10ps
`default_nettype none

module async_fifo #(
    parameter int ADDR_WIDTH = 4
) (
    input  wire logic               wr_clk,
    input  wire logic               wr_rst,
    input  wire logic               wr_en,
    input  wire decim_pkg::sample_t wr_data,
    output logic                    fifo_full,

    input  wire logic               rd_clk,
    input  wire logic               rd_rst,
    input  wire logic               rd_en,
    output decim_pkg::sample_t      rd_data,
    output logic                    fifo_empty
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    decim_pkg::sample_t mem [DEPTH];

    // One extra bit over the address tells full from empty
    logic [ADDR_WIDTH:0] wr_ptr_bin;
    logic [ADDR_WIDTH:0] wr_ptr_gray;
    logic [ADDR_WIDTH:0] wr_ptr_bin_next;
    logic [ADDR_WIDTH:0] rd_ptr_bin;
    logic [ADDR_WIDTH:0] rd_ptr_gray;
    logic [ADDR_WIDTH:0] rd_ptr_bin_next;

    // Pointers seen from the other domain
    logic [ADDR_WIDTH:0] rd_gray_sync1;
    logic [ADDR_WIDTH:0] rd_gray_sync2;
    logic [ADDR_WIDTH:0] wr_gray_sync1;
    logic [ADDR_WIDTH:0] wr_gray_sync2;

    logic wr_push;
    logic rd_pop;

    assign wr_push         = wr_en && !fifo_full;
    assign rd_pop          = rd_en && !fifo_empty;
    assign wr_ptr_bin_next = wr_ptr_bin + 1'b1;
    assign rd_ptr_bin_next = rd_ptr_bin + 1'b1;

    // Write side
    always_ff @(posedge wr_clk) begin
        if (wr_push) begin
            mem[wr_ptr_bin[ADDR_WIDTH-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge wr_clk or posedge wr_rst) begin
        if (wr_rst) begin
            wr_ptr_bin  <= '0;
            wr_ptr_gray <= '0;
        end else if (wr_push) begin
            wr_ptr_bin  <= wr_ptr_bin_next;
            wr_ptr_gray <= wr_ptr_bin_next ^ (wr_ptr_bin_next >> 1);
        end
    end

    // Read side, data is registered so it shows up the cycle after the pop
    always_ff @(posedge rd_clk) begin
        if (rd_pop) begin
            rd_data <= mem[rd_ptr_bin[ADDR_WIDTH-1:0]];
        end
    end

    always_ff @(posedge rd_clk or posedge rd_rst) begin
        if (rd_rst) begin
            rd_ptr_bin  <= '0;
            rd_ptr_gray <= '0;
        end else if (rd_pop) begin
            rd_ptr_bin  <= rd_ptr_bin_next;
            rd_ptr_gray <= rd_ptr_bin_next ^ (rd_ptr_bin_next >> 1);
        end
    end

    // Read pointer into the write domain
    always_ff @(posedge wr_clk or posedge wr_rst) begin
        if (wr_rst) begin
            rd_gray_sync1 <= '0;
            rd_gray_sync2 <= '0;
        end else begin
            rd_gray_sync1 <= rd_ptr_gray;
            rd_gray_sync2 <= rd_gray_sync1;
        end
    end

    // Write pointer into the read domain
    always_ff @(posedge rd_clk or posedge rd_rst) begin
        if (rd_rst) begin
            wr_gray_sync1 <= '0;
            wr_gray_sync2 <= '0;
        end else begin
            wr_gray_sync1 <= wr_ptr_gray;
            wr_gray_sync2 <= wr_gray_sync1;
        end
    end

    // Full when the write pointer is one lap ahead
    assign fifo_full  = (wr_ptr_gray == {~rd_gray_sync2[ADDR_WIDTH:ADDR_WIDTH-1],
                                         rd_gray_sync2[ADDR_WIDTH-2:0]});
    assign fifo_empty = (rd_ptr_gray == wr_gray_sync2);

endmodule

`default_nettype wire

// ==== design/sample_drain.sv ====
// FIFO drain stage
// Pops one sample at a time and presents it as a valid/ready beat
`timescale 1ns/10ps
`default_nettype none

module sample_drain (
    input  wire logic               rd_clk,
    input  wire logic               rd_rst,
    input  wire logic               fifo_empty,
    input  wire decim_pkg::sample_t rd_data,
    output logic                    rd_en,
    output decim_pkg::drain_beat_t  beat,
    input  wire logic               accept
);

    logic               pop_pending;
    logic               beat_valid;
    decim_pkg::sample_t beat_data;
    logic               beat_done;

    assign beat_done = beat_valid && accept;

    // Pop only when the output register is sure to be free once data returns
    assign rd_en = !fifo_empty && !pop_pending && (!beat_valid || accept);

    // Tracks the one-cycle read latency of the FIFO
    always_ff @(posedge rd_clk or posedge rd_rst) begin
        if (rd_rst) begin
            pop_pending <= 1'b0;
        end else begin
            pop_pending <= rd_en;
        end
    end

    always_ff @(posedge rd_clk or posedge rd_rst) begin
        if (rd_rst) begin
            beat_valid <= 1'b0;
        end else if (pop_pending) begin
            beat_valid <= 1'b1;
        end else if (beat_done) begin
            beat_valid <= 1'b0;
        end
    end

    // Register is empty whenever a pop is pending
    always_ff @(posedge rd_clk) begin
        if (pop_pending) begin
            beat_data <= rd_data;
        end
    end

    assign beat = '{valid: beat_valid, data: beat_data};

endmodule

`default_nettype wire

// ==== design/block_accumulator.sv ====
// Block accumulator
// Sums runs of blk_len samples and hands each total to the register stage
`timescale 1ns/10ps
`default_nettype none

module block_accumulator (
    input  wire logic                  rd_clk,
    input  wire logic                  rd_rst,
    input  wire decim_pkg::blk_len_t   blk_len,
    input  wire decim_pkg::drain_beat_t beat,
    output logic                       accept,
    output decim_pkg::acc_result_t     result,
    input  wire logic                  take
);

    decim_pkg::sum_t     sum_q;
    decim_pkg::sum_t     sum_next;
    decim_pkg::blk_len_t count_q;
    decim_pkg::blk_len_t count_next;
    decim_pkg::blk_len_t len_q;
    decim_pkg::blk_len_t cur_len;
    logic                res_valid;
    decim_pkg::sum_t     res_sum;
    logic                xfer;
    logic                block_end;

    // Stall only while a finished sum is still waiting
    assign accept = !(res_valid && !take);
    assign xfer   = beat.valid && accept;

    // Length is sampled at block start, so CTRL writes never split a block
    assign cur_len    = (count_q == '0) ? blk_len : len_q;
    assign sum_next   = sum_q + decim_pkg::sum_t'(beat.data);
    assign count_next = count_q + decim_pkg::blk_len_t'(1);
    assign block_end  = (count_next == cur_len);

    always_ff @(posedge rd_clk or posedge rd_rst) begin
        if (rd_rst) begin
            sum_q   <= '0;
            count_q <= '0;
            len_q   <= decim_pkg::BLK_LEN_RESET;
        end else if (xfer) begin
            if (count_q == '0) begin
                len_q <= blk_len;
            end
            if (block_end) begin
                sum_q   <= '0;
                count_q <= '0;
            end else begin
                sum_q   <= sum_next;
                count_q <= count_next;
            end
        end
    end

    // Result stays valid until take, a new total may replace it in the same cycle
    always_ff @(posedge rd_clk or posedge rd_rst) begin
        if (rd_rst) begin
            res_valid <= 1'b0;
        end else if (xfer && block_end) begin
            res_valid <= 1'b1;
        end else if (take) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge rd_clk) begin
        if (xfer && block_end) begin
            res_sum <= sum_next;
        end
    end

    assign result = '{valid: res_valid, sum: res_sum};

endmodule

`default_nettype wire

// ==== design/apb_result_regs.sv ====
// APB register slave
// CTRL, STATUS and a one-entry RESULT holding register, zero wait states
`timescale 1ns/10ps
`default_nettype none

module apb_result_regs (
    input  wire logic                   rd_clk,
    input  wire logic                   rd_rst,
    input  wire decim_pkg::apb_req_t    apb_req,
    output decim_pkg::apb_rsp_t         apb_rsp,
    output decim_pkg::blk_len_t         blk_len,
    input  wire decim_pkg::acc_result_t result,
    output logic                        take
);

    decim_pkg::blk_len_t ctrl_q;
    logic                hold_valid;
    decim_pkg::sum_t     hold_sum;
    logic                access;
    logic                wr_access;
    logic                rd_access;
    logic                result_pop;
    decim_pkg::apb_data_t prdata;
    logic                pslverr;

    // Access phase only, setup phase has no effect
    assign access    = apb_req.psel && apb_req.penable;
    assign wr_access = access && apb_req.pwrite;
    assign rd_access = access && !apb_req.pwrite;

    assign result_pop = rd_access && (apb_req.paddr == decim_pkg::REG_RESULT) && hold_valid;

    // CTRL, a zero length is ignored
    always_ff @(posedge rd_clk or posedge rd_rst) begin
        if (rd_rst) begin
            ctrl_q <= decim_pkg::BLK_LEN_RESET;
        end else if (wr_access && (apb_req.paddr == decim_pkg::REG_CTRL) &&
                     (apb_req.pwdata[7:0] != 8'd0)) begin
            ctrl_q <= apb_req.pwdata[7:0];
        end
    end

    assign blk_len = ctrl_q;

    // Holding register accepts a new sum only when empty
    assign take = !hold_valid;

    always_ff @(posedge rd_clk or posedge rd_rst) begin
        if (rd_rst) begin
            hold_valid <= 1'b0;
        end else if (take && result.valid) begin
            hold_valid <= 1'b1;
        end else if (result_pop) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge rd_clk) begin
        if (take && result.valid) begin
            hold_sum <= result.sum;
        end
    end

    // Read mux and error decode
    always_comb begin
        prdata  = '0;
        pslverr = 1'b0;
        if (access) begin
            case (apb_req.paddr)
                decim_pkg::REG_CTRL: begin
                    if (!apb_req.pwrite) begin
                        prdata = {24'd0, ctrl_q};
                    end
                end
                decim_pkg::REG_STATUS: begin
                    // Read only
                    pslverr = apb_req.pwrite;
                    if (!apb_req.pwrite) begin
                        prdata = {31'd0, hold_valid};
                    end
                end
                decim_pkg::REG_RESULT: begin
                    if (apb_req.pwrite || !hold_valid) begin
                        pslverr = 1'b1;
                    end else begin
                        prdata = {16'd0, hold_sum};
                    end
                end
                default: begin
                    pslverr = 1'b1;
                end
            endcase
        end
    end

    assign apb_rsp = '{prdata: prdata, pready: 1'b1, pslverr: pslverr};

endmodule

`default_nettype wire

// ==== design/decim_top.sv ====
// Sample decimator top
// Carries samples across clocks and sums them in blocks for an APB host
`timescale 1ns/10ps
`default_nettype none

module decim_top #(
    parameter int ADDR_WIDTH = 4
) (
    input  wire logic               wr_clk,
    input  wire logic               wr_rst,
    input  wire logic               wr_en,
    input  wire decim_pkg::sample_t wr_data,
    output logic                    fifo_full,

    input  wire logic               rd_clk,
    input  wire logic               rd_rst,
    input  wire decim_pkg::apb_req_t apb_req,
    output decim_pkg::apb_rsp_t     apb_rsp
);

    // FIFO read port
    logic                   rd_en;
    decim_pkg::sample_t     rd_data;
    logic                   fifo_empty;

    // Pipe between the rd_clk stages
    decim_pkg::drain_beat_t beat;
    logic                   accept;
    decim_pkg::acc_result_t result;
    logic                   take;
    decim_pkg::blk_len_t    blk_len;

    async_fifo #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_fifo (
        .wr_clk     (wr_clk),
        .wr_rst     (wr_rst),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .fifo_full  (fifo_full),
        .rd_clk     (rd_clk),
        .rd_rst     (rd_rst),
        .rd_en      (rd_en),
        .rd_data    (rd_data),
        .fifo_empty (fifo_empty)
    );

    sample_drain u_drain (
        .rd_clk     (rd_clk),
        .rd_rst     (rd_rst),
        .fifo_empty (fifo_empty),
        .rd_data    (rd_data),
        .rd_en      (rd_en),
        .beat       (beat),
        .accept     (accept)
    );

    block_accumulator u_acc (
        .rd_clk  (rd_clk),
        .rd_rst  (rd_rst),
        .blk_len (blk_len),
        .beat    (beat),
        .accept  (accept),
        .result  (result),
        .take    (take)
    );

    apb_result_regs u_regs (
        .rd_clk  (rd_clk),
        .rd_rst  (rd_rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .blk_len (blk_len),
        .result  (result),
        .take    (take)
    );

endmodule

`default_nettype wire

// ==== verif/tb_decim.sv ====
// Testbench for the sample decimator
// LFSR samples cross the FIFO, block sums are read back over APB and checked
`timescale 1ns/10ps
`default_nettype none

module tb_decim;

    localparam int ADDR_WIDTH  = 4;
    localparam int RD_PERIOD   = 20;
    localparam int WR_PERIOD   = 14;
    localparam int FULL_LIMIT  = 1000;
    localparam int POLL_LIMIT  = 200;
    localparam int BP_COUNT    = (1 << ADDR_WIDTH) + 4;
    localparam decim_pkg::blk_len_t DEFAULT_LEN = 8'd4;

    logic                  rd_clk;
    logic                  rd_rst;
    logic                  wr_clk;
    logic                  wr_rst;
    logic                  wr_en;
    decim_pkg::sample_t    wr_data;
    logic                  fifo_full;
    decim_pkg::apb_req_t   apb_req;
    decim_pkg::apb_rsp_t   apb_rsp;

    // Samples written but not yet summed
    decim_pkg::sample_t    model_q[$];
    logic [7:0]            lfsr_q;
    logic                  saw_full;
    logic                  writer_done;

    decim_top #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) dut0 (
        .wr_clk    (wr_clk),
        .wr_rst    (wr_rst),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .fifo_full (fifo_full),
        .rd_clk    (rd_clk),
        .rd_rst    (rd_rst),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp)
    );

    initial begin
        rd_clk = 1'b0;
        forever #(RD_PERIOD / 2) rd_clk = ~rd_clk;
    end

    initial begin
        wr_clk = 1'b0;
        forever #(WR_PERIOD / 2) wr_clk = ~wr_clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_sum(input string name, input decim_pkg::sum_t exp,
                             input decim_pkg::sum_t act);
        if (act !== exp) begin
            report_failure($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_len(input string name, input decim_pkg::blk_len_t exp,
                             input decim_pkg::blk_len_t act);
        if (act !== exp) begin
            report_failure($sformatf("Mismatch %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("Mismatch %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // Taps 8,6,5,4 give the maximal length sequence
    function automatic logic [7:0] lfsr_step(input logic [7:0] state);
        logic fb;
        fb = state[7] ^ state[5] ^ state[4] ^ state[3];
        return {state[6:0], fb};
    endfunction

    function automatic decim_pkg::sample_t next_sample();
        decim_pkg::sample_t s;
        s = '0;
        for (int i = 0; i < 8; i++) begin
            s      = {s[6:0], lfsr_q[7]};
            lfsr_q = lfsr_step(lfsr_q);
        end
        return s;
    endfunction

    // Expected sum of the next len samples taken from the model queue
    function automatic decim_pkg::sum_t block_sum(input decim_pkg::blk_len_t len);
        decim_pkg::sum_t total;
        total = '0;
        for (int i = 0; i < int'(len); i++) begin
            total = total + decim_pkg::sum_t'(model_q.pop_front());
        end
        return total;
    endfunction

    // Holds off while full so a sample is only modelled once accepted
    task automatic write_sample(input decim_pkg::sample_t s);
        int waited;
        waited = 0;
        @(negedge wr_clk);
        while (fifo_full) begin
            saw_full = 1'b1;
            wr_en    = 1'b0;
            if (waited >= FULL_LIMIT) begin
                report_failure("Timeout: fifo_full stayed high, producer could not write");
            end
            waited++;
            @(negedge wr_clk);
        end
        wr_en   = 1'b1;
        wr_data = s;
        model_q.push_back(s);
    endtask

    task automatic write_samples(input int count);
        for (int i = 0; i < count; i++) begin
            write_sample(next_sample());
        end
        @(negedge wr_clk);
        wr_en = 1'b0;
    endtask

    task automatic apb_access(input logic write, input decim_pkg::apb_addr_t addr,
                              input decim_pkg::apb_data_t wdata,
                              output decim_pkg::apb_data_t rdata, output logic slverr);
        @(negedge rd_clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge rd_clk);
        apb_req.penable = 1'b1;
        // Sample in the middle of the access phase
        #(RD_PERIOD / 4);
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        check_flag("pready", 1'b1, apb_rsp.pready);
        @(negedge rd_clk);
        apb_req = '0;
    endtask

    task automatic write_ctrl(input string name, input decim_pkg::blk_len_t len);
        decim_pkg::apb_data_t rdata;
        logic                 err;
        apb_access(1'b1, decim_pkg::REG_CTRL, {24'd0, len}, rdata, err);
        check_flag({name, " pslverr"}, 1'b0, err);
    endtask

    task automatic read_reg(input decim_pkg::apb_addr_t addr,
                            output decim_pkg::apb_data_t rdata, output logic err);
        apb_access(1'b0, addr, '0, rdata, err);
    endtask

    task automatic wait_result(input string name);
        decim_pkg::apb_data_t rdata;
        logic                 err;
        int                   polls;
        polls = 0;
        read_reg(decim_pkg::REG_STATUS, rdata, err);
        while (rdata[0] !== 1'b1) begin
            if (polls >= POLL_LIMIT) begin
                report_failure({"Timeout: no result appeared in STATUS for ", name});
            end
            polls++;
            read_reg(decim_pkg::REG_STATUS, rdata, err);
        end
    endtask

    task automatic read_result(input string name, input decim_pkg::blk_len_t len);
        decim_pkg::apb_data_t rdata;
        logic                 err;
        wait_result(name);
        read_reg(decim_pkg::REG_RESULT, rdata, err);
        check_flag({name, " pslverr"}, 1'b0, err);
        if (model_q.size() < int'(len)) begin
            report_failure({"DUT returned a result with too few samples written for ", name});
        end
        check_sum(name, block_sum(len), rdata[15:0]);
    endtask

    task automatic wait_flag(input string what, ref logic flag);
        int cycles;
        cycles = 0;
        while (!flag) begin
            if (cycles >= FULL_LIMIT) begin
                report_failure({"Timeout: ", what});
            end
            cycles++;
            @(negedge rd_clk);
        end
    endtask

    initial begin : main
        decim_pkg::apb_data_t rdata;
        logic                 err;
        wr_en       = 1'b0;
        wr_data     = '0;
        apb_req     = '0;
        rd_rst      = 1'b1;
        wr_rst      = 1'b1;
        lfsr_q      = 8'd62;
        saw_full    = 1'b0;
        writer_done = 1'b0;
        fork
            begin
                repeat (3) @(posedge rd_clk);
                @(negedge rd_clk);
                rd_rst = 1'b0;
            end
            begin
                repeat (3) @(posedge wr_clk);
                @(negedge wr_clk);
                wr_rst = 1'b0;
            end
        join

        // 1. Reset state
        read_reg(decim_pkg::REG_CTRL, rdata, err);
        check_len("reset ctrl", DEFAULT_LEN, rdata[7:0]);
        read_reg(decim_pkg::REG_STATUS, rdata, err);
        check_flag("reset status", 1'b0, rdata[0]);
        @(negedge wr_clk);
        check_flag("reset fifo_full", 1'b0, fifo_full);

        // 2. Default blocks of four
        write_samples(12);
        for (int i = 0; i < 3; i++) begin
            read_result($sformatf("default block %0d", i), DEFAULT_LEN);
        end

        // 3. Length change to seven
        write_ctrl("ctrl write 7", 8'd7);
        read_reg(decim_pkg::REG_CTRL, rdata, err);
        check_len("ctrl readback 7", 8'd7, rdata[7:0]);
        write_samples(21);
        for (int i = 0; i < 3; i++) begin
            read_result($sformatf("length 7 block %0d", i), 8'd7);
        end

        // 4. Back-pressure while the host holds off reading
        write_ctrl("ctrl write 1", 8'd1);
        saw_full = 1'b0;
        fork
            begin
                write_samples(BP_COUNT);
                writer_done = 1'b1;
            end
        join_none
        wait_flag("fifo_full never went high", saw_full);
        for (int i = 0; i < BP_COUNT; i++) begin
            read_result($sformatf("backpressure result %0d", i), 8'd1);
        end
        wait_flag("producer never finished writing", writer_done);
        read_reg(decim_pkg::REG_STATUS, rdata, err);
        check_flag("backpressure extra result", 1'b0, rdata[0]);

        // 5. Error responses
        read_reg(decim_pkg::REG_RESULT, rdata, err);
        check_flag("empty result pslverr", 1'b1, err);
        check_sum("empty result data", 16'd0, rdata[15:0]);
        check_flag("empty result upper data", 1'b0, |rdata[31:16]);
        read_reg(8'h0C, rdata, err);
        check_flag("unmapped pslverr", 1'b1, err);
        check_sum("unmapped data", 16'd0, rdata[15:0]);

        // 6. Zero length write is ignored
        write_ctrl("ctrl write 3", 8'd3);
        write_ctrl("ctrl write 0", 8'd0);
        read_reg(decim_pkg::REG_CTRL, rdata, err);
        check_len("ctrl after zero write", 8'd3, rdata[7:0]);
        write_samples(3);
        read_result("old length block", 8'd3);
        read_reg(decim_pkg::REG_STATUS, rdata, err);
        check_flag("old length extra result", 1'b0, rdata[0]);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
design/decim_pkg.sv
design/async_fifo.sv
design/sample_drain.sv
design/block_accumulator.sv
design/apb_result_regs.sv
design/decim_top.sv
verif/tb_decim.sv

// ==== Makefile ====
# Verilator build and run for the sample decimator testbench

VERILATOR ?= verilator
TOP       ?= tb_decim
FLAGS     ?= --binary --timing -Wno-fatal
OBJ_DIR   ?= obj_dir
FILELIST  ?= project.f

.PHONY: sim clean

# The executable exits non-zero on $fatal, so make reports the failure
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
